// File: src/ray_pkg.sv
package ray_pkg;

  // Q8.8 signed fixed point
  typedef logic signed [15:0] fp;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  typedef logic [3:0] color_t;
  // column index, one extra code for the row end
  typedef logic [4:0] h_t;
  // row index, one extra code for the scan end
  typedef logic [3:0] v_t;

  typedef enum logic [1:0] {
    scene_octa  = 2'd0,
    scene_cube  = 2'd1,
    scene_floor = 2'd2
  } scene_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_eval = 2'd1,
    st_step = 2'd2,
    st_done = 2'd3
  } unit_state_t;

  localparam int DISPLAY_WIDTH     = 16;
  localparam int DISPLAY_HEIGHT    = 12;
  localparam int FB_DEPTH          = DISPLAY_WIDTH * DISPLAY_HEIGHT;
  localparam int FB_ADDR_W         = $clog2(FB_DEPTH);
  localparam int NUM_CORES_DEFAULT = 4;
  localparam int MAX_STEPS         = 15;

  localparam fp HIT_EPS      = 16'sd8;
  localparam fp H_FP_START   = -16'sd128;
  localparam fp V_FP_START   = -16'sd96;
  localparam fp FP_PIXEL_INC = 16'sd16;
  localparam fp OCTA_RADIUS  = 16'sd256;
  localparam fp CUBE_HALF    = 16'sd192;
  localparam fp FLOOR_HEIGHT = -16'sd256;

  function automatic fp fp_add(input fp a, input fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(input fp a, input fp b);
    return a - b;
  endfunction

  // full product, then drop the 8 extra fraction bits
  function automatic fp fp_mul(input fp a, input fp b);
    logic signed [31:0] prod;
    prod = a * b;
    return prod[23:8];
  endfunction

  // wraps on the most negative value
  function automatic fp fp_abs(input fp a);
    return a[15] ? -a : a;
  endfunction

  function automatic fp fp_max(input fp a, input fp b);
    return (a > b) ? a : b;
  endfunction

endpackage

// File: src/ray_unit.sv
`timescale 1ns/100ps

module ray_unit (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             start_in,
  input  logic             take_in,
  input  ray_pkg::vec3     origin_in,
  input  ray_pkg::vec3     base_dir_in,
  input  ray_pkg::scene_t  scene_in,
  input  ray_pkg::h_t      h_in,
  input  ray_pkg::v_t      v_in,
  input  ray_pkg::fp       hfp_in,
  input  ray_pkg::fp       vfp_in,
  output logic             ready_out,
  output logic             result_valid_out,
  output ray_pkg::h_t      h_out,
  output ray_pkg::v_t      v_out,
  output ray_pkg::color_t  color_out
);
  import ray_pkg::*;

  unit_state_t state;
  scene_t      scene_q;
  vec3         dir;
  vec3         point;
  h_t          h_q;
  v_t          v_q;
  color_t      color_q;
  logic [3:0]  step_cnt;
  fp           dist_now;
  fp           dist_q;
  fp           ax;
  fp           ay;
  fp           az;
  logic        hit;
  logic        out_of_steps;

  // distance field of the current point
  always_comb begin
    ax = fp_abs(point.x);
    ay = fp_abs(point.y);
    az = fp_abs(point.z);
    case (scene_q)
      scene_cube:  dist_now = fp_sub(fp_max(fp_max(ax, ay), az), CUBE_HALF);
      scene_floor: dist_now = fp_sub(point.y, FLOOR_HEIGHT);
      // unused fourth code falls back to the octahedron
      default:     dist_now = fp_sub(fp_add(fp_add(ax, ay), az), OCTA_RADIUS);
    endcase
  end

  assign hit          = dist_now < HIT_EPS;
  assign out_of_steps = step_cnt == MAX_STEPS;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (start_in) state <= st_eval;
        st_eval: state <= (hit || out_of_steps) ? st_done : st_step;
        st_step: state <= st_eval;
        st_done: if (take_in) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (state)
      st_idle: begin
        if (start_in) begin
          h_q      <= h_in;
          v_q      <= v_in;
          scene_q  <= scene_in;
          point    <= origin_in;
          dir.x    <= fp_add(base_dir_in.x, hfp_in);
          dir.y    <= fp_add(base_dir_in.y, vfp_in);
          dir.z    <= base_dir_in.z;
          step_cnt <= '0;
        end
      end
      st_eval: begin
        dist_q  <= dist_now;
        // shade darkens with every step taken
        color_q <= hit ? color_t'(4'hf - step_cnt) : '0;
      end
      st_step: begin
        point.x  <= fp_add(point.x, fp_mul(dir.x, dist_q));
        point.y  <= fp_add(point.y, fp_mul(dir.y, dist_q));
        point.z  <= fp_add(point.z, fp_mul(dir.z, dist_q));
        step_cnt <= step_cnt + 4'd1;
      end
      default: ;
    endcase
  end

  // a pulse already on its way counts as pending
  assign ready_out        = (state == st_idle) && !start_in;
  assign result_valid_out = (state == st_done) && !take_in;
  assign h_out            = h_q;
  assign v_out            = v_q;
  assign color_out        = color_q;

endmodule

// File: src/ray_marcher.sv
`timescale 1ns/100ps

module ray_marcher #(
  parameter int NUM_CORES = ray_pkg::NUM_CORES_DEFAULT
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  ray_pkg::vec3     pos_vec_in,
  input  ray_pkg::vec3     dir_vec_in,
  input  ray_pkg::scene_t  scene_sel_in,
  input  logic             toggle_checker_in,
  output ray_pkg::h_t      hcount_out,
  output ray_pkg::v_t      vcount_out,
  output ray_pkg::color_t  color_out,
  output logic             valid_out,
  output logic             new_frame_out
);
  import ray_pkg::*;

  localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

  // inputs held for the whole frame
  vec3    cur_pos;
  vec3    cur_dir;
  scene_t cur_scene;
  logic   cur_checker;

  h_t   hcount;
  v_t   vcount;
  fp    hcount_fp;
  fp    vcount_fp;
  logic [3:0] frame_cnt;
  logic [IDX_W-1:0] core_idx;

  h_t   assign_h;
  v_t   assign_v;
  fp    assign_hfp;
  fp    assign_vfp;
  logic [NUM_CORES-1:0] start_q;
  logic [NUM_CORES-1:0] take_q;

  logic [NUM_CORES-1:0] core_ready;
  logic [NUM_CORES-1:0] core_done;
  h_t     core_h     [NUM_CORES];
  v_t     core_v     [NUM_CORES];
  color_t core_color [NUM_CORES];

  logic scan_end;
  logic row_end;
  logic skip;

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
    ray_unit u_core (
      .clk_in           (clk_in),
      .rst_in           (rst_in),
      .start_in         (start_q[i]),
      .take_in          (take_q[i]),
      .origin_in        (cur_pos),
      .base_dir_in      (cur_dir),
      .scene_in         (cur_scene),
      .h_in             (assign_h),
      .v_in             (assign_v),
      .hfp_in           (assign_hfp),
      .vfp_in           (assign_vfp),
      .ready_out        (core_ready[i]),
      .result_valid_out (core_done[i]),
      .h_out            (core_h[i]),
      .v_out            (core_v[i]),
      .color_out        (core_color[i])
    );
  end

  assign scan_end = vcount == DISPLAY_HEIGHT;
  assign row_end  = hcount == DISPLAY_WIDTH;
  // checkerboard half flips with the frame counter
  assign skip     = cur_checker && (hcount[0] ^ vcount[0] ^ frame_cnt[0]);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      hcount        <= '0;
      vcount        <= v_t'(DISPLAY_HEIGHT);
      hcount_fp     <= H_FP_START;
      vcount_fp     <= V_FP_START;
      frame_cnt     <= '0;
      core_idx      <= '0;
      start_q       <= '0;
      new_frame_out <= 1'b0;
    end else begin
      start_q       <= '0;
      new_frame_out <= 1'b0;
      if (scan_end) begin
        // wait until every core is idle and drained
        if (&core_ready && !(|core_done)) begin
          new_frame_out <= 1'b1;
          frame_cnt     <= frame_cnt + 4'd1;
          hcount        <= '0;
          vcount        <= '0;
          hcount_fp     <= H_FP_START;
          vcount_fp     <= V_FP_START;
        end
      end else if (row_end) begin
        vcount    <= vcount + 4'd1;
        vcount_fp <= fp_add(vcount_fp, FP_PIXEL_INC);
        hcount    <= '0;
        hcount_fp <= H_FP_START;
      end else if (skip || core_ready[core_idx]) begin
        if (!skip) begin
          start_q[core_idx] <= 1'b1;
        end
        hcount    <= hcount + 5'd1;
        hcount_fp <= fp_add(hcount_fp, FP_PIXEL_INC);
      end
      core_idx <= (core_idx == IDX_W'(NUM_CORES - 1)) ? '0 : core_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (scan_end && &core_ready && !(|core_done)) begin
      cur_pos     <= pos_vec_in;
      cur_dir     <= dir_vec_in;
      cur_scene   <= scene_sel_in;
      cur_checker <= toggle_checker_in;
    end
    assign_h   <= hcount;
    assign_v   <= vcount;
    assign_hfp <= hcount_fp;
    assign_vfp <= vcount_fp;
  end

  // collect from the pointed core
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_out <= 1'b0;
      take_q    <= '0;
    end else begin
      take_q    <= '0;
      valid_out <= core_done[core_idx];
      if (core_done[core_idx]) begin
        take_q[core_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (core_done[core_idx]) begin
      hcount_out <= core_h[core_idx];
      vcount_out <= core_v[core_idx];
      color_out  <= core_color[core_idx];
    end
  end

endmodule

// File: src/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer (
  input  logic             clk_in,
  input  logic             wr_en_in,
  input  ray_pkg::h_t      wr_h_in,
  input  ray_pkg::v_t      wr_v_in,
  input  ray_pkg::color_t  wr_color_in,
  input  ray_pkg::h_t      rd_h_in,
  input  ray_pkg::v_t      rd_v_in,
  output ray_pkg::color_t  rd_color_out
);
  import ray_pkg::*;

  color_t mem [FB_DEPTH];

  logic [FB_ADDR_W-1:0] wr_addr;
  logic [FB_ADDR_W-1:0] rd_addr;

  // row major, one row per DISPLAY_WIDTH entries
  assign wr_addr = FB_ADDR_W'(wr_v_in) * FB_ADDR_W'(DISPLAY_WIDTH) + FB_ADDR_W'(wr_h_in);
  assign rd_addr = FB_ADDR_W'(rd_v_in) * FB_ADDR_W'(DISPLAY_WIDTH) + FB_ADDR_W'(rd_h_in);

  always_ff @(posedge clk_in) begin
    if (wr_en_in && (wr_addr < FB_DEPTH)) begin
      mem[wr_addr] <= wr_color_in;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk_in) begin
    rd_color_out <= mem[rd_addr];
  end

endmodule

// File: src/render_top.sv
`timescale 1ns/100ps

module render_top (
  input  logic             clk_in,
  input  logic             rst_in,
  input  ray_pkg::vec3     pos_vec_in,
  input  ray_pkg::vec3     dir_vec_in,
  input  ray_pkg::scene_t  scene_sel_in,
  input  logic             toggle_checker_in,
  output ray_pkg::h_t      hcount_out,
  output ray_pkg::v_t      vcount_out,
  output ray_pkg::color_t  color_out,
  output logic             valid_out,
  output logic             new_frame_out,
  input  ray_pkg::h_t      read_hcount_in,
  input  ray_pkg::v_t      read_vcount_in,
  output ray_pkg::color_t  read_color_out
);

  ray_marcher u_marcher (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .pos_vec_in        (pos_vec_in),
    .dir_vec_in        (dir_vec_in),
    .scene_sel_in      (scene_sel_in),
    .toggle_checker_in (toggle_checker_in),
    .hcount_out        (hcount_out),
    .vcount_out        (vcount_out),
    .color_out         (color_out),
    .valid_out         (valid_out),
    .new_frame_out     (new_frame_out)
  );

  // pixel stream also leaves the top for observation
  frame_buffer u_frame_buffer (
    .clk_in       (clk_in),
    .wr_en_in     (valid_out),
    .wr_h_in      (hcount_out),
    .wr_v_in      (vcount_out),
    .wr_color_in  (color_out),
    .rd_h_in      (read_hcount_in),
    .rd_v_in      (read_vcount_in),
    .rd_color_out (read_color_out)
  );

endmodule

// File: sim/render_model.svh
`ifndef RENDER_MODEL_SVH
`define RENDER_MODEL_SVH

// reference march in plain integer Q8.8 arithmetic wrapped to 16 bits

function automatic fp abs_q88(input fp a);
  int mag;
  mag = (a < 0) ? -int'(a) : int'(a);
  return fp'(mag);
endfunction

function automatic fp mul_q88(input fp a, input fp b);
  int prod;
  prod = int'(a) * int'(b);
  return fp'(prod >>> 8);
endfunction

function automatic fp scene_distance(input scene_t scene, input fp x, input fp y, input fp z);
  fp ax;
  fp ay;
  fp az;
  fp m;
  fp distance;
  ax = abs_q88(x);
  ay = abs_q88(y);
  az = abs_q88(z);
  m  = (ax > ay) ? ax : ay;
  m  = (m > az) ? m : az;
  case (scene)
    scene_cube:  distance = fp'(int'(m) - int'(CUBE_HALF));
    scene_floor: distance = fp'(int'(y) - int'(FLOOR_HEIGHT));
    default:     distance = fp'(int'(ax) + int'(ay) + int'(az) - int'(OCTA_RADIUS));
  endcase
  return distance;
endfunction

// shade of one pixel is 15 minus steps on a hit and 0 on a miss
function automatic color_t march_color(input vec3 origin, input vec3 base_dir,
                                       input scene_t scene, input int h, input int v);
  fp      px;
  fp      py;
  fp      pz;
  fp      dx;
  fp      dy;
  fp      dz;
  fp      distance;
  int     step;
  logic   done;
  color_t shade;
  px    = origin.x;
  py    = origin.y;
  pz    = origin.z;
  dx    = fp'(int'(base_dir.x) + int'(H_FP_START) + h * int'(FP_PIXEL_INC));
  dy    = fp'(int'(base_dir.y) + int'(V_FP_START) + v * int'(FP_PIXEL_INC));
  dz    = base_dir.z;
  done  = 1'b0;
  shade = '0;
  for (step = 0; step <= MAX_STEPS && !done; step++) begin
    distance = scene_distance(scene, px, py, pz);
    if (distance < HIT_EPS) begin
      shade = color_t'(15 - step);
      done  = 1'b1;
    end else if (step < MAX_STEPS) begin
      px = fp'(int'(px) + int'(mul_q88(dx, distance)));
      py = fp'(int'(py) + int'(mul_q88(dy, distance)));
      pz = fp'(int'(pz) + int'(mul_q88(dz, distance)));
    end
  end
  return shade;
endfunction

// even parity of column, row and frame number is traced
function automatic logic pixel_traced(input int h, input int v, input int frame,
                                      input logic checker_on);
  return !checker_on || (((h + v + frame) % 2) == 0);
endfunction

`endif

// File: sim/render_tb.sv
`timescale 1ns/100ps

module render_tb;
  import ray_pkg::*;

  typedef struct packed {
    vec3        pos;
    vec3        dir;
    scene_t     scene;
    logic       checker_on;
    logic [7:0] exp_writes;
  } stim_t;

  localparam int NUM_HAND    = 6;
  localparam int NUM_ROWS    = NUM_HAND + 2;
  localparam int CYCLE_LIMIT = NUM_ROWS * 3 * FB_DEPTH * 36;
  localparam logic [31:0] LCG_SEED = 32'hf88b_97ad;

  logic   clk_in;
  logic   rst_in;
  vec3    pos_vec_in;
  vec3    dir_vec_in;
  scene_t scene_sel_in;
  logic   toggle_checker_in;
  h_t     hcount_out;
  v_t     vcount_out;
  color_t color_out;
  logic   valid_out;
  logic   new_frame_out;
  h_t     read_hcount_in;
  v_t     read_vcount_in;
  color_t read_color_out;

  stim_t  table_rows [NUM_ROWS];
  stim_t  drive_row;
  stim_t  snap_row;
  stim_t  lat_row;
  logic   seen [FB_DEPTH];
  logic   written [FB_DEPTH] = '{default: 1'b0};
  color_t shadow [FB_DEPTH];
  logic   frame_open;
  int     frame_no;
  int     frame_writes;
  int     cycle_count = 0;

  `include "render_model.svh"

  render_top DUT (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .pos_vec_in        (pos_vec_in),
    .dir_vec_in        (dir_vec_in),
    .scene_sel_in      (scene_sel_in),
    .toggle_checker_in (toggle_checker_in),
    .hcount_out        (hcount_out),
    .vcount_out        (vcount_out),
    .color_out         (color_out),
    .valid_out         (valid_out),
    .new_frame_out     (new_frame_out),
    .read_hcount_in    (read_hcount_in),
    .read_vcount_in    (read_vcount_in),
    .read_color_out    (read_color_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic stim_t make_row(input int px, input int py, input int pz, input int dx,
                                     input int dy, input int dz, input scene_t scene,
                                     input logic checker_on);
    stim_t row;
    row.pos        = '{x: fp'(px), y: fp'(py), z: fp'(pz)};
    row.dir        = '{x: fp'(dx), y: fp'(dy), z: fp'(dz)};
    row.scene      = scene;
    row.checker_on = checker_on;
    row.exp_writes = checker_on ? 8'd96 : 8'd192;
    return row;
  endfunction

  // moved origin and next scene for the change in mid frame
  function automatic stim_t shifted_row(input stim_t row);
    stim_t alt;
    alt       = row;
    alt.pos.x = fp'(int'(row.pos.x) + 48);
    case (row.scene)
      scene_octa: alt.scene = scene_cube;
      scene_cube: alt.scene = scene_floor;
      default:    alt.scene = scene_octa;
    endcase
    return alt;
  endfunction

  task automatic build_table();
    stim_t       row;
    logic [31:0] rnd;
    int          k;
    table_rows[0] = make_row(0, 0, -768, 0, 0, 256, scene_octa, 1'b0);
    table_rows[1] = make_row(0, 0, -768, 0, 0, 256, scene_cube, 1'b1);
    table_rows[2] = make_row(0, 0, 0, 0, 0, 256, scene_floor, 1'b0);
    table_rows[3] = make_row(64, -32, -640, 16, 0, 224, scene_octa, 1'b1);
    table_rows[4] = make_row(128, 64, -896, -32, 16, 288, scene_cube, 1'b0);
    table_rows[5] = make_row(0, 128, -256, 0, -32, 256, scene_floor, 1'b1);
    // two more rows with jittered directions
    rnd = LCG_SEED;
    for (k = 0; k < 2; k++) begin
      row       = table_rows[1 + k * 3];
      rnd       = lcg_next(rnd);
      row.dir.x = fp'(int'(row.dir.x) + int'(rnd[31:26]) - 32);
      rnd       = lcg_next(rnd);
      row.dir.y = fp'(int'(row.dir.y) + int'(rnd[31:26]) - 32);
      table_rows[NUM_HAND + k] = row;
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_color(input color_t got, input color_t exp, input string what);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL %0t: %s colour %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_pixel(input h_t h, input v_t v);
    int addr;
    if (h >= DISPLAY_WIDTH || v >= DISPLAY_HEIGHT) begin
      stop_with_error($sformatf("FAIL %0t: write to (%0d,%0d) is off screen", $time, h, v));
    end
    addr = int'(v) * DISPLAY_WIDTH + int'(h);
    if (!pixel_traced(int'(h), int'(v), frame_no, lat_row.checker_on)) begin
      stop_with_error($sformatf("FAIL %0t: pixel (%0d,%0d) is in the skipped half of frame %0d",
                                $time, h, v, frame_no));
    end
    if (seen[addr]) begin
      stop_with_error($sformatf("FAIL %0t: pixel (%0d,%0d) written twice in frame %0d",
                                $time, h, v, frame_no));
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      stop_with_error($sformatf("FAIL %0t: frame %0d made %0d writes, expected %0d",
                                $time, frame_no, got, exp));
    end
  endtask

  task automatic record_write(input h_t h, input v_t v, input color_t c);
    color_t exp;
    int     addr;
    if (!frame_open) begin
      stop_with_error("a pixel write arrived before any frame had started");
    end
    check_pixel(h, v);
    exp = march_color(lat_row.pos, lat_row.dir, lat_row.scene, int'(h), int'(v));
    check_color(c, exp, $sformatf("pixel (%0d,%0d) of frame %0d", h, v, frame_no));
    addr         = int'(v) * DISPLAY_WIDTH + int'(h);
    seen[addr]   = 1'b1;
    written[addr] = 1'b1;
    shadow[addr] = exp;
    frame_writes = frame_writes + 1;
  endtask

  task automatic start_frame();
    int i;
    if (frame_open) begin
      check_count(frame_writes, int'(lat_row.exp_writes));
    end
    frame_open   = 1'b1;
    frame_no     = frame_no + 1;
    frame_writes = 0;
    // inputs as sampled by the edge that raised new_frame_out
    lat_row      = snap_row;
    for (i = 0; i < FB_DEPTH; i++) begin
      seen[i] = 1'b0;
    end
  endtask

  // outputs settle after the rising edge so sample on the falling one
  always @(negedge clk_in) begin
    if (rst_in) begin
      frame_open   = 1'b0;
      frame_no     = 0;
      frame_writes = 0;
    end else begin
      if (valid_out) begin
        record_write(hcount_out, vcount_out, color_out);
      end
      if (new_frame_out) begin
        start_frame();
      end
    end
    snap_row = drive_row;
  end

  always @(posedge clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_error($sformatf("timeout: run still going after %0d clock cycles", cycle_count));
    end
  end

  task automatic apply_inputs(input stim_t row);
    drive_row         = row;
    pos_vec_in        = row.pos;
    dir_vec_in        = row.dir;
    scene_sel_in      = row.scene;
    toggle_checker_in = row.checker_on;
  endtask

  task automatic wait_for_frame(input int n);
    do @(posedge clk_in); while (frame_no < n);
  endtask

  task automatic wait_for_writes(input int n);
    do @(posedge clk_in); while (frame_writes < n);
  endtask

  // read port has one cycle of latency
  task automatic read_back_frame();
    int h;
    int v;
    int addr;
    for (v = 0; v < DISPLAY_HEIGHT; v++) begin
      for (h = 0; h < DISPLAY_WIDTH; h++) begin
        @(posedge clk_in);
        #2;
        read_hcount_in = h_t'(h);
        read_vcount_in = v_t'(v);
        @(posedge clk_in);
        @(negedge clk_in);
        addr = v * DISPLAY_WIDTH + h;
        if (written[addr]) begin
          check_color(read_color_out, shadow[addr], $sformatf("read of (%0d,%0d)", h, v));
        end
      end
    end
  endtask

  initial begin
    rst_in         = 1'b1;
    read_hcount_in = '0;
    read_vcount_in = '0;
    build_table();
    apply_inputs(table_rows[0]);
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk_in);
      #2;
      apply_inputs(table_rows[r]);
      rst_in = 1'b1;
      repeat (16) @(posedge clk_in);
      #2;
      rst_in = 1'b0;
      // change the inputs part way through frames 1 and 2
      wait_for_frame(1);
      wait_for_writes(40);
      #2;
      apply_inputs(shifted_row(table_rows[r]));
      wait_for_frame(2);
      wait_for_writes(40);
      #2;
      apply_inputs(table_rows[r]);
      // frame 3 closes on the fourth pulse
      wait_for_frame(4);
      #2;
      rst_in = 1'b1;
      read_back_frame();
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+sim
src/ray_pkg.sv
src/ray_unit.sv
src/ray_marcher.sv
src/frame_buffer.sv
src/render_top.sv
sim/render_tb.sv

// File: Makefile
TOP := render_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir -o render_sim
	./obj_dir/render_sim 2>&1 | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
